//--- rtl/aluPkg.sv
package aluPkg;

  // datapath width, fixed for the whole design
  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] aluWordT;  // operand or result word
  typedef logic [2:0]        aluOpT;    // command opcode
  typedef logic [1:0]        aluSelT;   // slice output select

  // opcode encodings
  localparam aluOpT OP_ADD  = 3'd0;
  localparam aluOpT OP_SUB  = 3'd1;
  localparam aluOpT OP_XOR  = 3'd2;
  localparam aluOpT OP_SLT  = 3'd3;
  localparam aluOpT OP_AND  = 3'd4;
  localparam aluOpT OP_NAND = 3'd5;
  localparam aluOpT OP_NOR  = 3'd6;
  localparam aluOpT OP_OR   = 3'd7;

  // slice output mux positions
  localparam aluSelT SEL_SUM  = 2'd0;
  localparam aluSelT SEL_XOR  = 2'd1;
  localparam aluSelT SEL_NAND = 2'd2;
  localparam aluSelT SEL_NOR  = 2'd3;

  // slice and core controls
  typedef struct packed {
    aluSelT sel;      // which slice result goes out
    logic   invertB;  // flips b, doubles as carry-in of bit 0
    logic   arith;    // carry/overflow are meaningful
    logic   slt;      // replace result by less-than bit
  } aluCtrlT;

  typedef struct packed {
    logic carry;
    logic zero;
    logic overflow;
  } aluFlagsT;

  // control word of a plain add, also the state after reset
  localparam aluCtrlT CTRL_ADD = '{
    sel:     SEL_SUM,
    invertB: 1'b0,
    arith:   1'b1,
    slt:     1'b0
  };

endpackage

//--- rtl/aluOpDecode.sv
`timescale 1ns/1ps

module aluOpDecode (
  input  aluPkg::aluOpT   op,
  output aluPkg::aluCtrlT ctrl
);

  always_comb begin
    ctrl = aluPkg::CTRL_ADD;
    case (op)
      aluPkg::OP_ADD: begin
        ctrl = aluPkg::CTRL_ADD;
      end
      aluPkg::OP_SUB: begin  // a + ~b + 1
        ctrl = '{sel: aluPkg::SEL_SUM, invertB: 1'b1, arith: 1'b1, slt: 1'b0};
      end
      aluPkg::OP_SLT: begin
        // same subtract as SUB, the core picks the sign afterwards
        ctrl = '{sel: aluPkg::SEL_SUM, invertB: 1'b1, arith: 1'b1, slt: 1'b1};
      end
      aluPkg::OP_XOR: begin
        ctrl = '{sel: aluPkg::SEL_XOR, invertB: 1'b0, arith: 1'b0, slt: 1'b0};
      end
      aluPkg::OP_NAND: begin
        ctrl = '{sel: aluPkg::SEL_NAND, invertB: 1'b0, arith: 1'b0, slt: 1'b0};
      end
      aluPkg::OP_AND: begin  // nand output flipped
        ctrl = '{sel: aluPkg::SEL_NAND, invertB: 1'b1, arith: 1'b0, slt: 1'b0};
      end
      aluPkg::OP_NOR: begin
        ctrl = '{sel: aluPkg::SEL_NOR, invertB: 1'b0, arith: 1'b0, slt: 1'b0};
      end
      aluPkg::OP_OR: begin  // nor output flipped
        ctrl = '{sel: aluPkg::SEL_NOR, invertB: 1'b1, arith: 1'b0, slt: 1'b0};
      end
      default: begin
        ctrl = aluPkg::CTRL_ADD;
      end
    endcase
  end

endmodule

//--- rtl/aluBitSlice.sv
`timescale 1ns/1ps

module aluBitSlice (
  input  logic           a,
  input  logic           b,
  input  logic           invertB,
  input  logic           cin,
  input  aluPkg::aluSelT sel,
  output logic           out,
  output logic           cout
);

  logic bEff;
  logic sumBit;
  logic xorBit;
  logic nandBit;
  logic norBit;

  assign bEff = b ^ invertB;  // subtract path

  // full adder
  assign sumBit = a ^ bEff ^ cin;
  assign cout   = (a & bEff) | (cin & (a ^ bEff));

  // logic unit, inversion turns nand into and, nor into or
  assign xorBit  = a ^ b;
  assign nandBit = ~(a & b) ^ invertB;
  assign norBit  = ~(a | b) ^ invertB;

  always_comb begin
    case (sel)
      aluPkg::SEL_SUM: begin
        out = sumBit;
      end
      aluPkg::SEL_XOR: begin
        out = xorBit;
      end
      aluPkg::SEL_NAND: begin
        out = nandBit;
      end
      default: begin
        out = norBit;
      end
    endcase
  end

endmodule

//--- rtl/aluCore.sv
`timescale 1ns/1ps

module aluCore (
  input  logic             clk,
  input  logic             rstN,
  input  logic             go,
  input  aluPkg::aluWordT  operandA,
  input  aluPkg::aluWordT  operandB,
  input  aluPkg::aluCtrlT  ctrl,
  output aluPkg::aluWordT  result,
  output aluPkg::aluFlagsT flags,
  output logic             done
);

  localparam int MSB = aluPkg::WORD_W - 1;

  // carryChain[i] is the carry into bit i, top entry is the carry out
  logic [aluPkg::WORD_W:0] carryChain;
  aluPkg::aluWordT         sliceOut;
  aluPkg::aluWordT         finalResult;
  aluPkg::aluFlagsT        nextFlags;
  logic                    carryOut;
  logic                    overflowRaw;
  logic                    lessThan;

  assign carryChain[0] = ctrl.invertB;  // +1 when subtracting

  genvar i;
  generate
    for (i = 0; i < aluPkg::WORD_W; i = i + 1) begin : gSlice
      aluBitSlice i_aluBitSlice (
        .a       (operandA[i]),
        .b       (operandB[i]),
        .invertB (ctrl.invertB),
        .cin     (carryChain[i]),
        .sel     (ctrl.sel),
        .out     (sliceOut[i]),
        .cout    (carryChain[i+1])
      );
    end
  endgenerate

  assign carryOut    = carryChain[aluPkg::WORD_W];
  assign overflowRaw = carryChain[MSB] ^ carryOut;  // carry in vs out of sign bit

  // signed compare: sign of a-b, corrected when the subtract overflowed
  assign lessThan = sliceOut[MSB] ^ overflowRaw;

  always_comb begin
    if (ctrl.slt) begin
      finalResult = {{(aluPkg::WORD_W-1){1'b0}}, lessThan};
    end else begin
      finalResult = sliceOut;
    end
  end

  always_comb begin
    nextFlags.carry    = carryOut & ctrl.arith;     // cleared for logic ops
    nextFlags.overflow = overflowRaw & ctrl.arith;
    nextFlags.zero     = ~|finalResult;             // after slt replacement
  end

  // one-stage result register, loads only on go
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      result <= '0;
      flags  <= '0;
      done   <= 1'b0;
    end else begin
      done <= go;  // single-cycle pulse per go
      if (go) begin
        result <= finalResult;
        flags  <= nextFlags;
      end
    end
  end

endmodule

//--- rtl/aluCmdReg.sv
`timescale 1ns/1ps

module aluCmdReg (
  input  logic            clk,
  input  logic            rstN,
  input  logic            cmdWe,
  input  aluPkg::aluOpT   cmd,
  output aluPkg::aluCtrlT ctrl
);

  aluPkg::aluOpT   opReg;
  aluPkg::aluOpT   nextOp;
  aluPkg::aluCtrlT nextCtrl;

  // opcode seen after the coming edge
  assign nextOp = cmdWe ? cmd : opReg;

  aluOpDecode i_aluOpDecode (
    .op   (nextOp),
    .ctrl (nextCtrl)
  );

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      opReg <= aluPkg::OP_ADD;
    end else if (cmdWe) begin
      opReg <= cmd;
    end
  end

  // decoded word from a flop, so the slices see no decode glitches
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrl <= aluPkg::CTRL_ADD;
    end else begin
      ctrl <= nextCtrl;  // tracks opReg every cycle
    end
  end

endmodule

//--- rtl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
  input  logic             clk,
  input  logic             rstN,
  input  logic             cmdWe,
  input  aluPkg::aluOpT    cmd,
  input  logic             go,
  input  aluPkg::aluWordT  operandA,
  input  aluPkg::aluWordT  operandB,
  output aluPkg::aluWordT  result,
  output aluPkg::aluFlagsT flags,
  output logic             done
);

  aluPkg::aluCtrlT ctrl;  // registered controls into the datapath

  // configuration side
  aluCmdReg i_aluCmdReg (
    .clk   (clk),
    .rstN  (rstN),
    .cmdWe (cmdWe),
    .cmd   (cmd),
    .ctrl  (ctrl)
  );

  // datapath and result stage
  aluCore i_aluCore (
    .clk      (clk),
    .rstN     (rstN),
    .go       (go),
    .operandA (operandA),
    .operandB (operandB),
    .ctrl     (ctrl),
    .result   (result),
    .flags    (flags),
    .done     (done)
  );

endmodule

//--- bench/aluUnit_sva.sv
`timescale 1ns/1ps

module aluUnit_sva (
  input logic             clk,
  input logic             rstN,
  input logic             cmdWe,
  input aluPkg::aluOpT    cmd,
  input logic             go,
  input logic             done,
  input aluPkg::aluFlagsT flags
);

  int            assertFails = 0;
  aluPkg::aluOpT curOp;    // opcode held since the last command write
  logic          logicOp;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      curOp <= aluPkg::OP_ADD;
    end else if (cmdWe) begin
      curOp <= cmd;
    end
  end

  // everything except add, sub and slt
  assign logicOp = (curOp != aluPkg::OP_ADD) && (curOp != aluPkg::OP_SUB) &&
                   (curOp != aluPkg::OP_SLT);

  // fixed one-cycle latency
  goThenDone: assert property (@(posedge clk) disable iff (!rstN) go |=> done)
    else begin
      $error("done did not follow go by one cycle");
      assertFails++;
    end

  // done only ever answers a go
  noStrayDone: assert property (@(posedge clk) disable iff (!rstN) !go |=> !done)
    else begin
      $error("done rose without a go in the cycle before");
      assertFails++;
    end

  // logic ops leave carry and overflow cleared
  logicFlagsClear: assert property (@(posedge clk) disable iff (!rstN)
    go && logicOp |=> !flags.carry && !flags.overflow)
    else begin
      $error("carry or overflow set after a logic operation");
      assertFails++;
    end

endmodule

bind aluUnit aluUnit_sva i_aluUnitSva (
  .clk   (clk),
  .rstN  (rstN),
  .cmdWe (cmdWe),
  .cmd   (cmd),
  .go    (go),
  .done  (done),
  .flags (flags)
);

//--- bench/aluChecker.sv
`timescale 1ns/1ps

module aluChecker (
  input  logic             clk,
  input  logic             rstN,
  input  logic             go,
  input  aluPkg::aluOpT    expOp,
  input  aluPkg::aluWordT  expResult,
  input  aluPkg::aluFlagsT expFlags,
  input  logic             done,
  input  aluPkg::aluWordT  result,
  input  aluPkg::aluFlagsT flags,
  output int               passCount,
  output int               failCount
);

  // expected answer of the go seen at the previous edge
  logic             pendValid;
  aluPkg::aluOpT    pendOp;
  aluPkg::aluWordT  pendResult;
  aluPkg::aluFlagsT pendFlags;
  int               testNum;

  // outputs are read before this edge updates them
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pendValid  <= 1'b0;
      pendOp     <= aluPkg::OP_ADD;
      pendResult <= '0;
      pendFlags  <= '0;
      testNum    <= 0;
      passCount  <= 0;
      failCount  <= 0;
    end else begin
      pendValid  <= go;
      pendOp     <= expOp;
      pendResult <= expResult;
      pendFlags  <= expFlags;

      if (pendValid && !done) begin
        $display("test %0d: done missing one cycle after go", testNum);
        failCount <= failCount + 1;
        testNum   <= testNum + 1;
      end else if (!pendValid && done) begin
        $display("unexpected done with no go in the cycle before");
        failCount <= failCount + 1;
      end else if (pendValid) begin
        if (result !== pendResult || flags !== pendFlags) begin
          if (result !== pendResult) begin
            $display("** Error test %0d: result expected %h got %h",
                     testNum, pendResult, result);
          end
          if (flags !== pendFlags) begin  // {carry, zero, overflow}
            $display("** Error test %0d: flags expected %h got %h",
                     testNum, pendFlags, flags);
          end
          failCount <= failCount + 1;
        end else begin
          $display("test %0d op %0d: result %h flags %h ok",
                   testNum, pendOp, result, flags);
          passCount <= passCount + 1;
        end
        testNum <= testNum + 1;
      end
    end
  end

endmodule

//--- bench/aluTb.sv
`timescale 1ns/1ps

module aluTb;

  typedef struct packed {
    aluPkg::aluOpT    op;
    logic             rnd;  // operands and answer filled in at run time
    aluPkg::aluWordT  a;
    aluPkg::aluWordT  b;
    aluPkg::aluWordT  res;
    aluPkg::aluFlagsT flg;
  } testRowT;

  typedef struct packed {
    aluPkg::aluWordT  res;
    aluPkg::aluFlagsT flg;
  } answerT;

  localparam int NUM_ROWS       = 28;
  localparam int EXTRA_GOS      = 4;  // reset default plus back-to-back group
  localparam int TOTAL_TESTS    = NUM_ROWS + EXTRA_GOS;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_TESTS + 20;

  logic             clk;
  logic             rstN;
  logic             cmdWe;
  aluPkg::aluOpT    cmd;
  logic             go;
  aluPkg::aluWordT  operandA;
  aluPkg::aluWordT  operandB;
  aluPkg::aluWordT  result;
  aluPkg::aluFlagsT flags;
  logic             done;

  aluPkg::aluOpT    expOp;
  aluPkg::aluWordT  expResult;
  aluPkg::aluFlagsT expFlags;
  int               passCount;
  int               failCount;

  testRowT          testTable [NUM_ROWS];
  logic [31:0]      lfsrState;
  int               cycleCount = 0;

  aluUnit i_aluUnit (
    .clk      (clk),
    .rstN     (rstN),
    .cmdWe    (cmdWe),
    .cmd      (cmd),
    .go       (go),
    .operandA (operandA),
    .operandB (operandB),
    .result   (result),
    .flags    (flags),
    .done     (done)
  );

  aluChecker i_aluChecker (
    .clk       (clk),
    .rstN      (rstN),
    .go        (go),
    .expOp     (expOp),
    .expResult (expResult),
    .expFlags  (expFlags),
    .done      (done),
    .result    (result),
    .flags     (flags),
    .passCount (passCount),
    .failCount (failCount)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycleCount);
      $display("tests failed");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic nextRandomWord(output aluPkg::aluWordT w);
    w = '0;
    for (int k = 0; k < aluPkg::WORD_W; k++) begin
      lfsrState = lfsrNext(lfsrState);
      w = {w[aluPkg::WORD_W-2:0], lfsrState[0]};
    end
  endtask

  // expected answer from the arithmetic rules, signed compare for SLT
  function automatic answerT refModel(input aluPkg::aluOpT op, input aluPkg::aluWordT a,
                                      input aluPkg::aluWordT b);
    answerT      ans;
    logic [32:0] wide;
    ans = '0;
    case (op)
      aluPkg::OP_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        ans.res = wide[31:0];
        ans.flg.carry = wide[32];
        ans.flg.overflow = (a[31] == b[31]) && (wide[31] != a[31]);
      end
      aluPkg::OP_SUB, aluPkg::OP_SLT: begin
        wide = {1'b0, a} + {1'b0, ~b} + 33'd1;
        ans.res = wide[31:0];
        ans.flg.carry = wide[32];
        ans.flg.overflow = (a[31] != b[31]) && (wide[31] != a[31]);
        if (op == aluPkg::OP_SLT) begin
          ans.res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        end
      end
      aluPkg::OP_XOR:  ans.res = a ^ b;
      aluPkg::OP_AND:  ans.res = a & b;
      aluPkg::OP_NAND: ans.res = ~(a & b);
      aluPkg::OP_NOR:  ans.res = ~(a | b);
      default:         ans.res = a | b;
    endcase
    ans.flg.zero = (ans.res == '0);
    return ans;
  endfunction

  // flg is {carry, zero, overflow}
  function automatic testRowT makeRow(input aluPkg::aluOpT op, input logic rnd,
                                      input aluPkg::aluWordT a, input aluPkg::aluWordT b,
                                      input aluPkg::aluWordT res, input logic [2:0] flg);
    return '{op: op, rnd: rnd, a: a, b: b, res: res, flg: flg};
  endfunction

  task automatic loadTable();
    testTable[0]  = makeRow(aluPkg::OP_ADD, 0, 32'hffffffff, 32'h1, 32'h0, 3'b110);
    testTable[1]  = makeRow(aluPkg::OP_SUB, 0, 32'h5, 32'h5, 32'h0, 3'b110);
    testTable[2]  = makeRow(aluPkg::OP_SUB, 0, 32'h3, 32'h5, 32'hfffffffe, 3'b000);
    testTable[3]  = makeRow(aluPkg::OP_ADD, 0, 32'h7fffffff, 32'h1, 32'h80000000, 3'b001);
    testTable[4]  = makeRow(aluPkg::OP_SUB, 0, 32'h80000000, 32'h1, 32'h7fffffff, 3'b101);
    testTable[5]  = makeRow(aluPkg::OP_ADD, 0, 32'h80000000, 32'h7fffffff, 32'hffffffff,
                            3'b000);
    testTable[6]  = makeRow(aluPkg::OP_ADD, 0, 32'hffffffff, 32'h10, 32'hf, 3'b100);
    testTable[7]  = makeRow(aluPkg::OP_SLT, 0, 32'hffffffff, 32'h1, 32'h1, 3'b100);
    testTable[8]  = makeRow(aluPkg::OP_SLT, 0, 32'h7fffffff, 32'h80000000, 32'h0, 3'b011);
    testTable[9]  = makeRow(aluPkg::OP_SLT, 0, 32'h12345678, 32'h12345678, 32'h0, 3'b110);
    testTable[10] = makeRow(aluPkg::OP_XOR, 0, 32'hffffffff, 32'hffffffff, 32'h0, 3'b010);
    testTable[11] = makeRow(aluPkg::OP_AND, 0, 32'hffffffff, 32'h0, 32'h0, 3'b010);
    testTable[12] = makeRow(aluPkg::OP_NAND, 0, 32'h0, 32'h0, 32'hffffffff, 3'b000);
    testTable[13] = makeRow(aluPkg::OP_NOR, 0, 32'h0, 32'h0, 32'hffffffff, 3'b000);
    testTable[14] = makeRow(aluPkg::OP_OR, 0, 32'hffffffff, 32'h0, 32'hffffffff, 3'b000);
    testTable[15] = makeRow(aluPkg::OP_NAND, 0, 32'hffffffff, 32'hffffffff, 32'h0, 3'b010);
    testTable[16] = makeRow(aluPkg::OP_OR, 0, 32'h0, 32'h0, 32'h0, 3'b010);
    testTable[17] = makeRow(aluPkg::OP_XOR, 0, 32'ha5a5a5a5, 32'hffffffff, 32'h5a5a5a5a,
                            3'b000);
    // random operands from here on
    testTable[18] = makeRow(aluPkg::OP_ADD, 1, '0, '0, '0, 3'b000);
    testTable[19] = makeRow(aluPkg::OP_SUB, 1, '0, '0, '0, 3'b000);
    testTable[20] = makeRow(aluPkg::OP_SLT, 1, '0, '0, '0, 3'b000);
    testTable[21] = makeRow(aluPkg::OP_XOR, 1, '0, '0, '0, 3'b000);
    testTable[22] = makeRow(aluPkg::OP_AND, 1, '0, '0, '0, 3'b000);
    testTable[23] = makeRow(aluPkg::OP_NAND, 1, '0, '0, '0, 3'b000);
    testTable[24] = makeRow(aluPkg::OP_NOR, 1, '0, '0, '0, 3'b000);
    testTable[25] = makeRow(aluPkg::OP_OR, 1, '0, '0, '0, 3'b000);
    testTable[26] = makeRow(aluPkg::OP_ADD, 1, '0, '0, '0, 3'b000);
    testTable[27] = makeRow(aluPkg::OP_SUB, 1, '0, '0, '0, 3'b000);
  endtask

  // all drive tasks start and end on a falling edge
  task automatic writeCmd(input aluPkg::aluOpT op);
    cmdWe = 1'b1;
    cmd   = op;
    @(negedge clk);
    cmdWe = 1'b0;
  endtask

  task automatic driveGo(input aluPkg::aluOpT op, input aluPkg::aluWordT a,
                         input aluPkg::aluWordT b, input answerT exp);
    go        = 1'b1;
    operandA  = a;
    operandB  = b;
    expOp     = op;
    expResult = exp.res;
    expFlags  = exp.flg;
    @(negedge clk);
  endtask

  task automatic waitDone();
    go = 1'b0;
    while (!done) @(negedge clk);  // timeout counter covers a lost done
  endtask

  initial begin
    testRowT         row;
    aluPkg::aluWordT ra;
    aluPkg::aluWordT rb;
    clk       = 1'b0;
    rstN      = 1'b0;
    cmdWe     = 1'b0;
    cmd       = aluPkg::OP_ADD;
    go        = 1'b0;
    operandA  = '0;
    operandB  = '0;
    expOp     = aluPkg::OP_ADD;
    expResult = '0;
    expFlags  = '0;
    lfsrState = 32'hf37b;
    loadTable();
    repeat (3) @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);

    // no command written yet, so ADD
    driveGo(aluPkg::OP_ADD, 32'h10, 32'h20, refModel(aluPkg::OP_ADD, 32'h10, 32'h20));
    waitDone();

    for (int i = 0; i < NUM_ROWS; i++) begin
      row = testTable[i];
      if (row.rnd) begin
        nextRandomWord(row.a);
        nextRandomWord(row.b);
        {row.res, row.flg} = refModel(row.op, row.a, row.b);
      end
      writeCmd(row.op);
      driveGo(row.op, row.a, row.b, {row.res, row.flg});
      waitDone();
    end

    // one SUB command, three go pulses in a row
    writeCmd(aluPkg::OP_SUB);
    for (int j = 0; j < 3; j++) begin
      nextRandomWord(ra);
      nextRandomWord(rb);
      driveGo(aluPkg::OP_SUB, ra, rb, refModel(aluPkg::OP_SUB, ra, rb));
    end
    waitDone();

    repeat (2) @(negedge clk);  // last compare happens on the next rising edge
    if (passCount + failCount != TOTAL_TESTS) begin
      $display("%0d results checked for %0d operations launched",
               passCount + failCount, TOTAL_TESTS);
    end
    $display("run of %0d operations: %0d passed, %0d failed, %0d assertion failures",
             TOTAL_TESTS, passCount, failCount, i_aluUnit.i_aluUnitSva.assertFails);
    if (failCount == 0 && passCount == TOTAL_TESTS &&
        i_aluUnit.i_aluUnitSva.assertFails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- list.f
rtl/aluPkg.sv
rtl/aluOpDecode.sv
rtl/aluBitSlice.sv
rtl/aluCore.sv
rtl/aluCmdReg.sv
rtl/aluUnit.sv
bench/aluUnit_sva.sv
bench/aluChecker.sv
bench/aluTb.sv

//--- Bender.yml
package:
  name: alu_unit

sources:
  # synthesizable design, package first
  - rtl/aluPkg.sv
  - rtl/aluOpDecode.sv
  - rtl/aluBitSlice.sv
  - rtl/aluCore.sv
  - rtl/aluCmdReg.sv
  - rtl/aluUnit.sv

  # verification sources
  - target: test
    files:
      - bench/aluUnit_sva.sv
      - bench/aluChecker.sv
      - bench/aluTb.sv
